/* src/pkt_arb_pkg.sv */
//==================================================
// Channel count and control word layout are fixed here
// The channel number always sits in the top ctl bits
//==================================================
`default_nettype none

package pkt_arb_pkg;

  localparam int NUM_IN    = 4;                    // Input channels merged
  localparam int CHAN_BITS = $clog2(NUM_IN);       // Width of a channel number
  localparam int CTL_BITS  = 8;                    // Full control word
  localparam int USER_BITS = CTL_BITS - CHAN_BITS; // Bits left to the user

  // Decoded view of the control word
  typedef struct packed {
    logic [CHAN_BITS-1:0] chan;  // Source channel, stamped on ingress
    logic [USER_BITS-1:0] user;  // Passed through untouched
  } ctl_fields_t;

  // Same 8 bits, seen either whole or split into fields
  typedef union packed {
    logic [CTL_BITS-1:0] raw;
    ctl_fields_t         fields;
  } ctl_word_u;

endpackage

`default_nettype wire

/* src/pkt_ingress_slice.sv */
//==================================================
// Holds one word. Upper ctl bits are replaced by i_chan
//==================================================
`timescale 1ns/10ps
`default_nettype none

module pkt_ingress_slice #(
  parameter int  DAT_BYTS = 8,
  localparam int DAT_BITS = DAT_BYTS * 8,
  localparam int MOD_BITS = (DAT_BYTS > 1) ? $clog2(DAT_BYTS) : 1
) (
  input  wire                              i_clk,
  input  wire                              i_rst,
  input  wire  [pkt_arb_pkg::CHAN_BITS-1:0] i_chan,  // Tied per slot at the top
  // Incoming stream
  input  wire                              i_val,
  input  wire                              i_sop,
  input  wire                              i_eop,
  input  wire                              i_err,
  input  wire  [DAT_BITS-1:0]              i_dat,
  input  wire  [MOD_BITS-1:0]              i_mod,
  input  wire  [pkt_arb_pkg::CTL_BITS-1:0]  i_ctl,
  output logic                             o_rdy,
  // Held word towards the arbiter
  output logic                             o_val,
  output logic                             o_sop,
  output logic                             o_eop,
  output logic                             o_err,
  output logic [DAT_BITS-1:0]              o_dat,
  output logic [MOD_BITS-1:0]              o_mod,
  output logic [pkt_arb_pkg::CTL_BITS-1:0]  o_ctl,
  input  wire                              i_rdy
);

  pkt_arb_pkg::ctl_word_u ctl_stamp;  // Incoming ctl with chan field overwritten

  // Free when empty, or when the held word leaves on this edge
  assign o_rdy = ~o_val | i_rdy;

  always_comb begin
    ctl_stamp             = pkt_arb_pkg::ctl_word_u'(i_ctl);
    ctl_stamp.fields.chan = i_chan;  // User bits stay as they came in
  end

  // Occupancy flag
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_val <= 1'b0;
    end else if (o_rdy) begin
      o_val <= i_val;  // Reload or go empty
    end
  end

  // Payload follows the valid flag
  always_ff @(posedge i_clk) begin
    if (o_rdy) begin
      o_sop <= i_sop;
      o_eop <= i_eop;
      o_err <= i_err;
      o_dat <= i_dat;
      o_mod <= i_mod;
      o_ctl <= ctl_stamp.raw;
    end
  end

endmodule

`default_nettype wire

/* src/pkt_rr_arbiter.sv */
//==================================================
// Round robin that holds a channel for a whole packet
// Output is combinational from the selected held word
//==================================================
`timescale 1ns/10ps
`default_nettype none

module pkt_rr_arbiter #(
  parameter int  DAT_BYTS = 8,
  localparam int DAT_BITS = DAT_BYTS * 8,
  localparam int MOD_BITS = (DAT_BYTS > 1) ? $clog2(DAT_BYTS) : 1
) (
  input  wire                                                        i_clk,
  input  wire                                                        i_rst,
  // Per-channel held words from the ingress slices
  input  wire  [pkt_arb_pkg::NUM_IN-1:0]                             i_val,
  input  wire  [pkt_arb_pkg::NUM_IN-1:0]                             i_sop,
  input  wire  [pkt_arb_pkg::NUM_IN-1:0]                             i_eop,
  input  wire  [pkt_arb_pkg::NUM_IN-1:0]                             i_err,
  input  wire  [pkt_arb_pkg::NUM_IN-1:0][DAT_BITS-1:0]               i_dat,
  input  wire  [pkt_arb_pkg::NUM_IN-1:0][MOD_BITS-1:0]               i_mod,
  input  wire  [pkt_arb_pkg::NUM_IN-1:0][pkt_arb_pkg::CTL_BITS-1:0]  i_ctl,
  output logic [pkt_arb_pkg::NUM_IN-1:0]                             o_rdy,
  // Merged stream
  output logic                                                       o_val,
  output logic                                                       o_sop,
  output logic                                                       o_eop,
  output logic                                                       o_err,
  output logic [DAT_BITS-1:0]                                        o_dat,
  output logic [MOD_BITS-1:0]                                        o_mod,
  output logic [pkt_arb_pkg::CTL_BITS-1:0]                           o_ctl,
  input  wire                                                        i_rdy
);

  logic [pkt_arb_pkg::CHAN_BITS-1:0] sel_idx;  // Channel currently routed out
  logic [pkt_arb_pkg::CHAN_BITS-1:0] nxt_idx;  // Next channel with val after sel_idx
  logic                              locked;   // Mid-packet, sel_idx frozen
  logic                              eop_fire; // Last word of packet transfers

  // Search starts just after cur and wraps, cur itself is checked last
  function automatic logic [pkt_arb_pkg::CHAN_BITS-1:0] next_valid(
    input logic [pkt_arb_pkg::NUM_IN-1:0]    val,
    input logic [pkt_arb_pkg::CHAN_BITS-1:0] cur
  );
    int   cand;
    logic found;
    next_valid = cur;  // Nothing pending keeps the current index
    found      = 1'b0;
    for (int i = 1; i <= pkt_arb_pkg::NUM_IN; i++) begin
      cand = (int'(cur) + i) % pkt_arb_pkg::NUM_IN;
      if (!found && val[cand]) begin
        next_valid = cand[pkt_arb_pkg::CHAN_BITS-1:0];
        found      = 1'b1;
      end
    end
  endfunction

  assign nxt_idx  = next_valid(i_val, sel_idx);
  assign eop_fire = o_val & o_eop & i_rdy;

  // Output mux, ready goes back to the selected channel only
  always_comb begin
    o_rdy          = '0;
    o_rdy[sel_idx] = i_rdy;
    o_val          = i_val[sel_idx];
    o_sop          = i_sop[sel_idx];
    o_eop          = i_eop[sel_idx];
    o_err          = i_err[sel_idx];
    o_dat          = i_dat[sel_idx];
    o_mod          = i_mod[sel_idx];
    o_ctl          = i_ctl[sel_idx];
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      sel_idx <= '0;
      locked  <= 1'b0;
    end else if (eop_fire) begin
      locked  <= 1'b0;      // Packet done
      sel_idx <= nxt_idx;   // Move on so the same channel waits its turn
    end else if (o_val) begin
      locked  <= 1'b1;      // Hold this channel until its eop
    end else if (!locked) begin
      sel_idx <= nxt_idx;   // Idle, hunt for a pending channel
    end
    // Locked with a gap in val: keep waiting on the same channel
  end

endmodule

`default_nettype wire

/* src/pkt_egress_slice.sv */
//==================================================
// Two-entry skid buffer. o_rdy is a flop output so no
// ready path runs combinationally through the block
//==================================================
`timescale 1ns/10ps
`default_nettype none

module pkt_egress_slice #(
  parameter int  DAT_BYTS = 8,
  localparam int DAT_BITS = DAT_BYTS * 8,
  localparam int MOD_BITS = (DAT_BYTS > 1) ? $clog2(DAT_BYTS) : 1
) (
  input  wire                              i_clk,
  input  wire                              i_rst,
  // Merged stream from the arbiter
  input  wire                              i_val,
  input  wire                              i_sop,
  input  wire                              i_eop,
  input  wire                              i_err,
  input  wire  [DAT_BITS-1:0]              i_dat,
  input  wire  [MOD_BITS-1:0]              i_mod,
  input  wire  [pkt_arb_pkg::CTL_BITS-1:0]  i_ctl,
  output logic                             o_rdy,
  // Registered output stream (main register)
  output logic                             o_val,
  output logic                             o_sop,
  output logic                             o_eop,
  output logic                             o_err,
  output logic [DAT_BITS-1:0]              o_dat,
  output logic [MOD_BITS-1:0]              o_mod,
  output logic [pkt_arb_pkg::CTL_BITS-1:0]  o_ctl,
  input  wire                              i_rdy
);

  // Spare register catches the word in flight when the output stalls
  logic                            sp_val;
  logic                            sp_sop;
  logic                            sp_eop;
  logic                            sp_err;
  logic [DAT_BITS-1:0]             sp_dat;
  logic [MOD_BITS-1:0]             sp_mod;
  logic [pkt_arb_pkg::CTL_BITS-1:0] sp_ctl;
  logic                            main_free;  // Main empty or draining this edge
  logic                            spare_load;

  assign o_rdy      = ~sp_val;                  // Room as long as spare is empty
  assign main_free  = ~o_val | i_rdy;
  assign spare_load = i_val & o_rdy & ~main_free;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_val  <= 1'b0;
      sp_val <= 1'b0;
    end else if (main_free) begin
      o_val  <= sp_val | i_val;  // Spare first, else the new word
      sp_val <= 1'b0;
    end else begin
      sp_val <= sp_val | spare_load;
    end
  end

  // Payload moves
  always_ff @(posedge i_clk) begin
    if (main_free) begin
      o_sop <= sp_val ? sp_sop : i_sop;
      o_eop <= sp_val ? sp_eop : i_eop;
      o_err <= sp_val ? sp_err : i_err;
      o_dat <= sp_val ? sp_dat : i_dat;
      o_mod <= sp_val ? sp_mod : i_mod;
      o_ctl <= sp_val ? sp_ctl : i_ctl;
    end
    if (spare_load) begin
      sp_sop <= i_sop;
      sp_eop <= i_eop;
      sp_err <= i_err;
      sp_dat <= i_dat;
      sp_mod <= i_mod;
      sp_ctl <= i_ctl;
    end
  end

endmodule

`default_nettype wire

/* src/pkt_arb_top.sv */
//==================================================
// Merges NUM_IN packet streams without interleaving
// Top ctl bits on the output carry the source channel
//==================================================
`timescale 1ns/10ps
`default_nettype none

module pkt_arb_top #(
  parameter int  DAT_BYTS = 8,
  localparam int DAT_BITS = DAT_BYTS * 8,
  localparam int MOD_BITS = (DAT_BYTS > 1) ? $clog2(DAT_BYTS) : 1
) (
  input  wire                                                       i_clk,
  input  wire                                                       i_rst,
  // Input channels, one slot each
  input  wire [pkt_arb_pkg::NUM_IN-1:0]                             i_s_val,
  input  wire [pkt_arb_pkg::NUM_IN-1:0]                             i_s_sop,
  input  wire [pkt_arb_pkg::NUM_IN-1:0]                             i_s_eop,
  input  wire [pkt_arb_pkg::NUM_IN-1:0]                             i_s_err,
  input  wire [pkt_arb_pkg::NUM_IN-1:0][DAT_BITS-1:0]               i_s_dat,
  input  wire [pkt_arb_pkg::NUM_IN-1:0][MOD_BITS-1:0]               i_s_mod,
  input  wire [pkt_arb_pkg::NUM_IN-1:0][pkt_arb_pkg::CTL_BITS-1:0]  i_s_ctl,
  output wire [pkt_arb_pkg::NUM_IN-1:0]                             o_s_rdy,
  // Merged output
  output wire                                                       o_m_val,
  output wire                                                       o_m_sop,
  output wire                                                       o_m_eop,
  output wire                                                       o_m_err,
  output wire [DAT_BITS-1:0]                                        o_m_dat,
  output wire [MOD_BITS-1:0]                                        o_m_mod,
  output wire [pkt_arb_pkg::CTL_BITS-1:0]                           o_m_ctl,
  input  wire                                                       i_m_rdy
);

  // Ingress slices to arbiter
  wire [pkt_arb_pkg::NUM_IN-1:0]                            ing_val;
  wire [pkt_arb_pkg::NUM_IN-1:0]                            ing_sop;
  wire [pkt_arb_pkg::NUM_IN-1:0]                            ing_eop;
  wire [pkt_arb_pkg::NUM_IN-1:0]                            ing_err;
  wire [pkt_arb_pkg::NUM_IN-1:0][DAT_BITS-1:0]              ing_dat;
  wire [pkt_arb_pkg::NUM_IN-1:0][MOD_BITS-1:0]              ing_mod;
  wire [pkt_arb_pkg::NUM_IN-1:0][pkt_arb_pkg::CTL_BITS-1:0] ing_ctl;
  wire [pkt_arb_pkg::NUM_IN-1:0]                            ing_rdy;  // From arbiter

  // Arbiter to egress slice
  wire                            arb_val;
  wire                            arb_sop;
  wire                            arb_eop;
  wire                            arb_err;
  wire [DAT_BITS-1:0]             arb_dat;
  wire [MOD_BITS-1:0]             arb_mod;
  wire [pkt_arb_pkg::CTL_BITS-1:0] arb_ctl;
  wire                            arb_rdy;

  for (genvar g = 0; g < pkt_arb_pkg::NUM_IN; g++) begin : g_ing
    localparam logic [pkt_arb_pkg::CHAN_BITS-1:0] CHAN_ID = g;  // Stamped into ctl

    pkt_ingress_slice #(.DAT_BYTS(DAT_BYTS)) u_ing (
      .i_clk  (i_clk),      .i_rst  (i_rst),      .i_chan (CHAN_ID),
      .i_val  (i_s_val[g]), .i_sop  (i_s_sop[g]), .i_eop  (i_s_eop[g]),
      .i_err  (i_s_err[g]), .i_dat  (i_s_dat[g]), .i_mod  (i_s_mod[g]),
      .i_ctl  (i_s_ctl[g]), .o_rdy  (o_s_rdy[g]),
      .o_val  (ing_val[g]), .o_sop  (ing_sop[g]), .o_eop  (ing_eop[g]),
      .o_err  (ing_err[g]), .o_dat  (ing_dat[g]), .o_mod  (ing_mod[g]),
      .o_ctl  (ing_ctl[g]), .i_rdy  (ing_rdy[g])
    );
  end

  pkt_rr_arbiter #(.DAT_BYTS(DAT_BYTS)) u_arb (
    .i_clk (i_clk),   .i_rst (i_rst),
    .i_val (ing_val), .i_sop (ing_sop), .i_eop (ing_eop), .i_err (ing_err),
    .i_dat (ing_dat), .i_mod (ing_mod), .i_ctl (ing_ctl), .o_rdy (ing_rdy),
    .o_val (arb_val), .o_sop (arb_sop), .o_eop (arb_eop), .o_err (arb_err),
    .o_dat (arb_dat), .o_mod (arb_mod), .o_ctl (arb_ctl), .i_rdy (arb_rdy)
  );

  pkt_egress_slice #(.DAT_BYTS(DAT_BYTS)) u_egr (
    .i_clk (i_clk),   .i_rst (i_rst),
    .i_val (arb_val), .i_sop (arb_sop), .i_eop (arb_eop), .i_err (arb_err),
    .i_dat (arb_dat), .i_mod (arb_mod), .i_ctl (arb_ctl), .o_rdy (arb_rdy),
    .o_val (o_m_val), .o_sop (o_m_sop), .o_eop (o_m_eop), .o_err (o_m_err),
    .o_dat (o_m_dat), .o_mod (o_m_mod), .o_ctl (o_m_ctl), .i_rdy (i_m_rdy)
  );

endmodule

`default_nettype wire

/* bench/pkt_arb_asserts.sv */
//==================================================
// Watches the merged output of pkt_arb_top only
//==================================================
`timescale 1ns/10ps
`default_nettype none

module pkt_arb_asserts #(
  parameter int  DAT_BYTS = 8,
  localparam int DAT_BITS = DAT_BYTS * 8,
  localparam int MOD_BITS = (DAT_BYTS > 1) ? $clog2(DAT_BYTS) : 1
) (
  input wire                             i_clk,
  input wire                             i_rst,
  input wire                             o_m_val,
  input wire                             o_m_sop,
  input wire                             o_m_eop,
  input wire                             o_m_err,
  input wire [DAT_BITS-1:0]              o_m_dat,
  input wire [MOD_BITS-1:0]              o_m_mod,
  input wire [pkt_arb_pkg::CTL_BITS-1:0] o_m_ctl,
  input wire                             i_m_rdy
);

  logic open_pkt;  // Between an accepted sop and its eop

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      open_pkt <= 1'b0;
    end else if (o_m_val && i_m_rdy) begin
      open_pkt <= ~o_m_eop;  // Single-word packet leaves it closed
    end
  end

  // Stalled word must not change
  hold_on_stall: assert property (@(posedge i_clk) disable iff (i_rst)
    o_m_val && !i_m_rdy |=> $stable({o_m_val, o_m_sop, o_m_eop, o_m_err,
                                    o_m_dat, o_m_mod, o_m_ctl}))
    else $error("merged output changed while stalled");

  idle_in_reset: assert property (@(posedge i_clk) i_rst |=> !o_m_val)
    else $error("o_m_val high during reset");

  no_nested_sop: assert property (@(posedge i_clk) disable iff (i_rst)
    o_m_val && open_pkt |-> !o_m_sop)
    else $error("sop inside an open packet");

endmodule

bind pkt_arb_top pkt_arb_asserts #(.DAT_BYTS(DAT_BYTS)) u_asserts (
  .i_clk   (i_clk),   .i_rst   (i_rst),   .o_m_val (o_m_val), .o_m_sop (o_m_sop),
  .o_m_eop (o_m_eop), .o_m_err (o_m_err), .o_m_dat (o_m_dat), .o_m_mod (o_m_mod),
  .o_m_ctl (o_m_ctl), .i_m_rdy (i_m_rdy)
);

`default_nettype wire

/* bench/pkt_arb_tb.sv */
//==================================================
// Reads bench/pkt_arb_vectors.txt relative to the project root
// Vector data fields assume DAT_BYTS of 8
//==================================================
`timescale 1ns/10ps
`default_nettype none

module pkt_arb_tb;

  localparam int DAT_BYTS  = 8;
  localparam int DAT_BITS  = DAT_BYTS * 8;
  localparam int MOD_BITS  = $clog2(DAT_BYTS);
  localparam int NUM_IN    = pkt_arb_pkg::NUM_IN;
  localparam int CHAN_BITS = pkt_arb_pkg::CHAN_BITS;
  localparam int NUM_PKT   = 12;  // Lines in the vector file
  localparam int EXP_W     = 3 + MOD_BITS + pkt_arb_pkg::CTL_BITS + DAT_BITS;

  logic                                          i_clk;
  logic                                          i_rst;
  logic [NUM_IN-1:0]                             i_s_val;
  logic [NUM_IN-1:0]                             i_s_sop;
  logic [NUM_IN-1:0]                             i_s_eop;
  logic [NUM_IN-1:0]                             i_s_err;
  logic [NUM_IN-1:0][DAT_BITS-1:0]               i_s_dat;
  logic [NUM_IN-1:0][MOD_BITS-1:0]               i_s_mod;
  logic [NUM_IN-1:0][pkt_arb_pkg::CTL_BITS-1:0]  i_s_ctl;
  wire  [NUM_IN-1:0]                             o_s_rdy;
  wire                                           o_m_val;
  wire                                           o_m_sop;
  wire                                           o_m_eop;
  wire                                           o_m_err;
  wire  [DAT_BITS-1:0]                           o_m_dat;
  wire  [MOD_BITS-1:0]                           o_m_mod;
  wire  [pkt_arb_pkg::CTL_BITS-1:0]              o_m_ctl;
  logic                                          i_m_rdy;

  logic [63:0]          vec [0:NUM_PKT*5-1];   // Five fields per packet
  logic [EXP_W-1:0]     exp_q [NUM_IN][$];      // {sop, eop, err, mod, ctl, dat}
  int                   pkts_left [NUM_IN];     // Packets not yet started at output
  logic [CHAN_BITS-1:0] prev_chan = CHAN_BITS'(NUM_IN - 1);  // So channel 0 goes first
  int                   total_words = 0;
  int                   words_seen  = 0;

  pkt_arb_top #(.DAT_BYTS(DAT_BYTS)) u_dut (
    .i_clk   (i_clk),   .i_rst   (i_rst),
    .i_s_val (i_s_val), .i_s_sop (i_s_sop), .i_s_eop (i_s_eop), .i_s_err (i_s_err),
    .i_s_dat (i_s_dat), .i_s_mod (i_s_mod), .i_s_ctl (i_s_ctl), .o_s_rdy (o_s_rdy),
    .o_m_val (o_m_val), .o_m_sop (o_m_sop), .o_m_eop (o_m_eop), .o_m_err (o_m_err),
    .o_m_dat (o_m_dat), .o_m_mod (o_m_mod), .o_m_ctl (o_m_ctl), .i_m_rdy (i_m_rdy)
  );

  task automatic stop_on_error(string msg);
    $display("%s", msg);
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic check_word(string name, logic [DAT_BITS-1:0] exp_v, logic [DAT_BITS-1:0] act);
    if (act !== exp_v) begin
      stop_on_error($sformatf("FAILED %0t %s expected %h got %h", $time, name, exp_v, act));
    end
  endtask

  task automatic check_mod(string name, logic [MOD_BITS-1:0] exp_v,
                           logic [MOD_BITS-1:0] act);
    if (act !== exp_v) begin
      stop_on_error($sformatf("FAILED %0t %s expected %0d got %0d", $time, name, exp_v, act));
    end
  endtask

  task automatic check_ctl(string name, pkt_arb_pkg::ctl_word_u exp_v,
                           pkt_arb_pkg::ctl_word_u act);
    if (act.raw !== exp_v.raw) begin
      stop_on_error($sformatf("FAILED %0t %s expected chan %0d user %h got chan %0d user %h",
        $time, name, exp_v.fields.chan, exp_v.fields.user, act.fields.chan, act.fields.user));
    end
  endtask

  task automatic check_flag(string name, logic exp_v, logic act);
    if (act !== exp_v) begin
      stop_on_error($sformatf("FAILED %0t %s expected %b got %b", $time, name, exp_v, act));
    end
  endtask

  task automatic check_chan(string name, logic [CHAN_BITS-1:0] exp_v,
                            logic [CHAN_BITS-1:0] act);
    if (act !== exp_v) begin
      stop_on_error($sformatf("FAILED %0t %s expected %0d got %0d", $time, name, exp_v, act));
    end
  endtask

  function automatic int pkt_len(int p);
    return int'(vec[p*5+2]);
  endfunction

  // Next packet of channel c after index from or NUM_PKT when none is left
  function automatic int next_pkt(int c, int from);
    for (int p = from + 1; p < NUM_PKT; p++) begin
      if (int'(vec[p*5]) == c) return p;
    end
    return NUM_PKT;
  endfunction

  // Word w of packet p with the output chan when stamp is set, else its inverse
  function automatic logic [EXP_W-1:0] make_word(int p, int w, logic stamp);
    pkt_arb_pkg::ctl_word_u ctl;
    logic [CHAN_BITS-1:0]   chan;
    logic                   eop;
    logic [MOD_BITS-1:0]    mod;
    chan            = vec[p*5][CHAN_BITS-1:0];
    eop             = (w == pkt_len(p) - 1);
    mod             = eop ? MOD_BITS'((pkt_len(p) % (DAT_BYTS - 1)) + 1) : '0;  // Never 0 on eop
    ctl.fields.user = vec[p*5+1][pkt_arb_pkg::USER_BITS-1:0];
    ctl.fields.chan = stamp ? chan : ~chan;  // Inverted input the DUT has to overwrite
    return {(w == 0), eop, eop & vec[p*5+4][0], mod, ctl.raw,
            DAT_BITS'(vec[p*5+3]) + DAT_BITS'(w)};
  endfunction

  // First channel after the last winner that still owes a packet
  function automatic logic [CHAN_BITS-1:0] next_turn();
    logic [CHAN_BITS-1:0] cand;
    cand = prev_chan;
    for (int i = 0; i < NUM_IN; i++) begin
      cand = cand + 1'b1;  // NUM_IN is a power of two so this wraps
      if (pkts_left[cand] > 0) return cand;
    end
    return prev_chan;
  endfunction

  task automatic check_output();
    pkt_arb_pkg::ctl_word_u act_ctl;
    pkt_arb_pkg::ctl_word_u exp_ctl;
    logic [EXP_W-1:0]       exp_w;
    logic                   e_sop;
    logic                   e_eop;
    logic                   e_err;
    logic [MOD_BITS-1:0]    e_mod;
    logic [DAT_BITS-1:0]    e_dat;
    int                     c;
    act_ctl = pkt_arb_pkg::ctl_word_u'(o_m_ctl);
    c       = int'(act_ctl.fields.chan);
    if (o_m_sop) begin
      check_chan("o_m_ctl.chan at sop", next_turn(), act_ctl.fields.chan);  // Round robin
      prev_chan    = act_ctl.fields.chan;
      pkts_left[c] = pkts_left[c] - 1;
    end else begin
      check_chan("o_m_ctl.chan inside packet", prev_chan, act_ctl.fields.chan);
    end
    if (exp_q[c].size() == 0) begin
      stop_on_error($sformatf("Extra output word at %0t from channel %0d", $time, c));
    end
    exp_w = exp_q[c].pop_front();
    {e_sop, e_eop, e_err, e_mod, exp_ctl.raw, e_dat} = exp_w;
    check_word("o_m_dat", e_dat, o_m_dat);
    check_mod("o_m_mod", e_mod, o_m_mod);
    check_ctl("o_m_ctl", exp_ctl, act_ctl);
    check_flag("o_m_sop", e_sop, o_m_sop);
    check_flag("o_m_eop", e_eop, o_m_eop);
    check_flag("o_m_err", e_err, o_m_err);
    words_seen++;
  endtask

  initial begin : clk_gen
    i_clk = 1'b0;
    forever #4 i_clk = ~i_clk;
  end

  initial begin : main
    int ch;
    int total;
    i_rst   = 1'b1;
    i_s_val = '0;
    i_s_sop = '0;
    i_s_eop = '0;
    i_s_err = '0;
    i_s_dat = '0;
    i_s_mod = '0;
    i_s_ctl = '0;
    i_m_rdy = 1'b0;
    total   = 0;
    for (int c = 0; c < NUM_IN; c++) pkts_left[c] = 0;
    $readmemh("bench/pkt_arb_vectors.txt", vec);
    for (int p = 0; p < NUM_PKT; p++) begin
      ch = int'(vec[p*5][CHAN_BITS-1:0]);
      pkts_left[ch]++;
      for (int w = 0; w < pkt_len(p); w++) exp_q[ch].push_back(make_word(p, w, 1'b1));
      total += pkt_len(p);
    end
    total_words = total;
    repeat (4) @(posedge i_clk);
    #1 i_rst = 1'b0;
    @(negedge i_clk);  // First cycle out of reset
    check_flag("o_m_val", 1'b0, o_m_val);
    for (int c = 0; c < NUM_IN; c++) check_flag($sformatf("o_s_rdy[%0d]", c), 1'b1, o_s_rdy[c]);
    wait (words_seen == total_words);
    repeat (20) @(negedge i_clk);  // Room for stray extra words
    if (o_m_val === 1'b0) begin
      $display("No errors");
      $finish;
    end else begin
      stop_on_error("Output still held a word after every expected word had arrived");
    end
  end

  // Drives all channels and i_m_rdy 1 ns after each edge
  initial begin : drive
    int                cur [NUM_IN];   // Packet index per channel
    int                wcnt [NUM_IN];  // Words already accepted from that packet
    logic [NUM_IN-1:0] acc;
    void'($urandom(86));
    wait (total_words > 0 && !i_rst);
    for (int c = 0; c < NUM_IN; c++) begin
      cur[c]  = next_pkt(c, -1);
      wcnt[c] = 0;
    end
    forever begin
      @(negedge i_clk);
      acc = i_s_val & o_s_rdy;  // Transfers on the coming edge
      @(posedge i_clk);
      #1;
      i_m_rdy = ($urandom_range(9) > 2);
      for (int c = 0; c < NUM_IN; c++) begin
        if (acc[c]) begin
          wcnt[c]++;
          if (wcnt[c] == pkt_len(cur[c])) begin
            cur[c]  = next_pkt(c, cur[c]);
            wcnt[c] = 0;
          end
        end
        if (cur[c] >= NUM_PKT) begin
          i_s_val[c] = 1'b0;  // Channel done
        end else if (!i_s_val[c] || acc[c]) begin
          if (wcnt[c] != 0 && $urandom_range(3) == 0) begin
            i_s_val[c] = 1'b0;  // Gap inside a packet only
          end else begin
            i_s_val[c] = 1'b1;
            {i_s_sop[c], i_s_eop[c], i_s_err[c], i_s_mod[c], i_s_ctl[c], i_s_dat[c]} =
              make_word(cur[c], wcnt[c], 1'b0);
          end
        end
      end
    end
  end

  initial begin : monitor
    forever begin
      @(negedge i_clk);
      if (!i_rst && o_m_val && i_m_rdy) check_output();
    end
  end

  initial begin : watchdog
    wait (total_words > 0);
    repeat (total_words * 40 + 200) @(posedge i_clk);
    stop_on_error("Watchdog expired because the output stalled before all packets arrived");
  end

endmodule

`default_nettype wire

/* flist.f */
src/pkt_arb_pkg.sv
src/pkt_ingress_slice.sv
src/pkt_rr_arbiter.sv
src/pkt_egress_slice.sv
src/pkt_arb_top.sv
bench/pkt_arb_asserts.sv
bench/pkt_arb_tb.sv

/* Makefile */
# Verilator build and run of the packet arbiter testbench
SRCS := $(shell cat flist.f)

.PHONY: run clean

run: obj_dir/Vpkt_arb_tb
	./obj_dir/Vpkt_arb_tb

# Rebuilt only when a source or the file list changes
obj_dir/Vpkt_arb_tb: flist.f $(SRCS)
	verilator --binary --timing --assert --top-module pkt_arb_tb -f flist.f

clean:
	rm -rf obj_dir

/* bench/pkt_arb_vectors.txt */
// One packet per line, all hex: chan user words first_data err
// err marks the eop word of that packet
0 05 3 0000000000001000 0
1 2a 1 0000000000002000 0
2 11 5 0000000000003000 1
3 3f 2 0000000000004000 0
0 00 1 0000000000005000 1
1 15 4 0000000000006000 0
3 20 6 0000000000007000 0
0 0c 2 ffffffffffff0000 0
2 33 2 0000000000008000 0
1 01 3 0000000000009000 1
0 1e 4 000000000000a000 0
3 07 1 000000000000b000 1
